//--- emesh_cdc.f
+incdir+tests
common/emesh_pkg.sv
fifo/fifo_memory_dp.sv
fifo/fifo_ptr_sync.sv
fifo/fifo_async.sv
rtl/wr_arbiter.sv
rtl/emesh_cdc_top.sv
tests/tb_emesh_cdc.sv

//--- tests/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

//######################################################################
// reference model
//######################################################################

logic    ord_q[$];    // winning source of every grant, grant order
packet_t src0_q[$];   // granted from source 0
packet_t src1_q[$];   // granted from source 1

// no grant while full, a conflict goes to the source that lost last time
function automatic logic [1:0] expect_grant(input logic [1:0] r, input logic f,
                                            input logic last);
   logic [1:0] g;
   g = 2'b00;
   if (!f && (r == 2'b11)) begin
      g[~last] = 1'b1;
   end else if (!f) begin
      g = r;   // lone requester or idle
   end
   return g;
endfunction

// winner's packet as it should land in the fifo
function automatic void record_grant(input logic idx, input packet_t raw);
   packet_t p;
   p     = raw;
   p.src = idx;   // tag replaced by the winning index
   ord_q.push_back(idx);
   if (idx) begin
      src1_q.push_back(p);
   end else begin
      src0_q.push_back(p);
   end
endfunction

task automatic stop_run(input string what);
   $display("%s", what);
   $display("TB FAILED");
   $fatal(1, "run stopped at first error");
endtask

task automatic check_pkt(input string name, input packet_t exp, input packet_t act);
   if (exp !== act) begin
      stop_run($sformatf("ERR %s expected %h actual %h", name, exp, act));
   end
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
   if (exp !== act) begin
      stop_run($sformatf("ERR %s expected %b actual %b", name, exp, act));
   end
endtask

// dout loaded at the last rd_clk edge
task automatic check_read();
   logic    exp_idx;
   packet_t exp;
   if (ord_q.size() == 0) begin
      stop_run("fifo returned a packet that was never granted");
   end else begin
      exp_idx = ord_q.pop_front();
      check_flag("read order src", exp_idx, dout.src);   // interleave across sources
      if (exp_idx) begin
         exp = src1_q.pop_front();
      end else begin
         exp = src0_q.pop_front();
      end
      check_pkt("source order", exp, dout);   // per source fifo order
   end
endtask

`endif

//--- tests/tb_emesh_cdc.sv
`timescale 1ns/1ns

module tb_emesh_cdc;
   import emesh_pkg::*;

   localparam int unsigned RAND_SEED = 32'h63b7_9f71;
   localparam int NUM_PKT     = 400;
   localparam int RESET_CYC   = 16;
   localparam int TRAFFIC_CYC = NUM_PKT * 3;            // read side sets the pace
   localparam int FILL_CYC    = FIFO_DEPTH + 40;        // fill, hold while full, settle
   localparam int DRAIN_CYC   = 2 * FIFO_DEPTH * 3;     // two drains
   localparam int TIMEOUT_CYC = 4 * (RESET_CYC + TRAFFIC_CYC + FILL_CYC + DRAIN_CYC);

   logic            nreset;
   logic            wr_clk;
   logic            rd_clk;
   logic [1:0]      req;
   packet_t [1:0]   pkt_in;
   logic [1:0]      gnt;
   logic            rd_en;
   packet_t         dout;
   logic            empty;
   logic            full;
   logic            prog_full;

   logic            src_on;       // sources may raise new requests
   logic            rd_on;        // reader may pulse rd_en
   logic            fill_mode;    // exact flag checks, reads stopped
   int              req_pct;
   int              rd_pct;
   logic            model_last;   // model's last winner
   logic [1:0]      gnt_seen;     // grants taken at the last wr_clk edge
   logic [1:0]      exp_gnt;
   int              grant_cnt;
   int              fill_cnt;
   int              cycle_cnt = 0;

   `include "tb_checks.svh"

   emesh_cdc_top i_dut (
      .nreset    (nreset),
      .wr_clk    (wr_clk),
      .rd_clk    (rd_clk),
      .req       (req),
      .pkt_in    (pkt_in),
      .gnt       (gnt),
      .rd_en     (rd_en),
      .dout      (dout),
      .empty     (empty),
      .full      (full),
      .prog_full (prog_full)
   );

   initial begin
      wr_clk = 1'b0;
      forever #2 wr_clk = ~wr_clk;   // 4 ns
   end

   initial begin
      rd_clk = 1'b0;
      forever #3 rd_clk = ~rd_clk;   // 6 ns
   end

   //######################################################################
   // stimulus, falling edges only
   //######################################################################

   // a source holds req and packet until its grant was taken
   task automatic drive_sources();
      forever begin
         @(negedge wr_clk);
         for (int i = 0; i < 2; i++) begin
            if (gnt_seen[i] || !req[i]) begin
               if (src_on && ($urandom_range(99) < req_pct)) begin
                  req[i]         = 1'b1;
                  pkt_in[i].src  = $urandom_range(1);   // junk, arbiter restamps
                  pkt_in[i].data = $urandom;
               end else begin
                  req[i] = 1'b0;
               end
            end
         end
      end
   endtask

   task automatic drive_reads();
      forever begin
         @(negedge rd_clk);
         if (rd_en) begin
            check_read();
         end
         rd_en = rd_on && !empty && ($urandom_range(99) < rd_pct);
      end
   endtask

   // outstanding work gone, sources idle
   task automatic drain_fifo();
      while ((req != 2'b00) || (ord_q.size() != 0)) begin
         @(posedge rd_clk);
      end
   endtask

   //######################################################################
   // grant monitor, values taken before the edge updates them
   //######################################################################

   always @(posedge wr_clk) begin
      if (nreset) begin
         exp_gnt = expect_grant(req, full, model_last);
         check_flag("arbiter gnt[0]", exp_gnt[0], gnt[0]);
         check_flag("arbiter gnt[1]", exp_gnt[1], gnt[1]);
         if (fill_mode) begin
            check_flag("fill full", fill_cnt == FIFO_DEPTH, full);
            check_flag("fill prog_full", fill_cnt >= PROG_FULL, prog_full);
            if (req == 2'b11) begin
               check_flag("fill grant", fill_cnt < FIFO_DEPTH, |gnt);
            end
         end
         for (int i = 0; i < 2; i++) begin
            if (gnt[i]) begin
               record_grant(i[0], pkt_in[i]);
               model_last = i[0];
               grant_cnt++;
               if (fill_mode) begin
                  fill_cnt++;
               end
            end
         end
         gnt_seen = gnt;
      end
   end

   always @(posedge wr_clk) begin
      cycle_cnt++;
      if (cycle_cnt >= TIMEOUT_CYC) begin
         stop_run($sformatf("timeout, run still going after %0d wr_clk cycles",
                            TIMEOUT_CYC));
      end
   end

   //######################################################################
   // test sequence, control changes on rd_clk rising edges
   //######################################################################

   initial begin
      void'($urandom(RAND_SEED));
      nreset     = 1'b0;
      req        = 2'b00;
      pkt_in     = '0;
      rd_en      = 1'b0;
      src_on     = 1'b0;
      rd_on      = 1'b0;
      fill_mode  = 1'b0;
      req_pct    = 60;
      rd_pct     = 70;
      model_last = 1'b1;   // source 0 takes the first conflict
      gnt_seen   = 2'b00;
      grant_cnt  = 0;
      fill_cnt   = 0;
      repeat (RESET_CYC) @(posedge wr_clk);
      @(negedge wr_clk);
      nreset = 1'b1;

      // reset state
      repeat (2) @(posedge rd_clk);
      check_flag("reset gnt[0]", 1'b0, gnt[0]);
      check_flag("reset gnt[1]", 1'b0, gnt[1]);
      check_flag("reset empty", 1'b1, empty);
      check_flag("reset full", 1'b0, full);
      check_flag("reset prog_full", 1'b0, prog_full);

      fork
         drive_sources();
         drive_reads();
      join_none

      // random traffic, order and round-robin checked on the fly
      src_on = 1'b1;
      rd_on  = 1'b1;
      while (grant_cnt < NUM_PKT) begin
         @(posedge rd_clk);
      end
      src_on = 1'b0;
      drain_fifo();

      // fill from empty with reads stopped
      rd_on = 1'b0;
      repeat (8) @(posedge rd_clk);   // read pointer settles on the write side
      fill_cnt  = 0;
      req_pct   = 100;
      fill_mode = 1'b1;
      src_on    = 1'b1;
      while (fill_cnt < FIFO_DEPTH) begin
         @(posedge rd_clk);
      end
      repeat (16) @(posedge rd_clk);  // held full, no grant expected

      // resume reads and drain the rest
      fill_mode = 1'b0;
      src_on    = 1'b0;
      rd_on     = 1'b1;
      drain_fifo();
      repeat (12) begin
         @(posedge rd_clk);
         check_flag("empty after drain", 1'b1, empty);
      end
      $display("TB PASSED");
      $finish;
   end

endmodule

//--- rtl/emesh_cdc_top.sv
`timescale 1ns/1ns

module emesh_cdc_top (
   input  logic                     nreset,
   input  logic                     wr_clk,
   input  logic                     rd_clk,
   input  logic [1:0]               req,
   input  emesh_pkg::packet_t [1:0] pkt_in,
   output logic [1:0]               gnt,
   input  logic                     rd_en,
   output emesh_pkg::packet_t       dout,
   output logic                     empty,
   output logic                     full,
   output logic                     prog_full
);
   import emesh_pkg::*;

   logic    wr_en;      // arbiter write strobe
   packet_t fifo_din;   // tagged winner packet

   //######################################################################
   // wr_clk side, two sources onto one write port
   //######################################################################

   wr_arbiter i_arb (
      .nreset (nreset),
      .wr_clk (wr_clk),
      .req    (req),
      .pkt_in (pkt_in),
      .full   (full),       // back-pressure straight from fifo
      .gnt    (gnt),
      .wr_en  (wr_en),
      .din    (fifo_din)
   );

   //######################################################################
   // crossing into rd_clk
   //######################################################################

   fifo_async i_fifo (
      .nreset    (nreset),
      .wr_clk    (wr_clk),
      .wr_en     (wr_en),
      .din       (fifo_din),
      .rd_clk    (rd_clk),
      .rd_en     (rd_en),
      .dout      (dout),
      .empty     (empty),
      .full      (full),
      .prog_full (prog_full)
   );

endmodule

//--- rtl/wr_arbiter.sv
`timescale 1ns/1ns

module wr_arbiter (
   input  logic                     nreset,
   input  logic                     wr_clk,
   input  logic [1:0]               req,
   input  emesh_pkg::packet_t [1:0] pkt_in,
   input  logic                     full,
   output logic [1:0]               gnt,
   output logic                     wr_en,
   output emesh_pkg::packet_t       din
);
   import emesh_pkg::*;

   logic last_win;   // source granted most recently
   logic win_idx;    // source chosen this cycle

   //######################################################################
   // round-robin pick
   //######################################################################

   always_comb begin
      if (req[0] && req[1]) begin
         win_idx = ~last_win;   // conflict, other source goes
      end else begin
         win_idx = req[1];      // lone requester, or 0 when idle
      end
   end

   // grant is combinational, write lands in the same cycle
   always_comb begin
      gnt = 2'b00;
      if (!full && (req != 2'b00)) begin
         gnt[win_idx] = 1'b1;   // held off entirely while full
      end
   end

   assign wr_en = |gnt;

   // winner's packet, src stamped with its index
   always_comb begin
      din     = pkt_in[win_idx];
      din.src = win_idx;
   end

   // starts at 1 so source 0 takes the first conflict
   always_ff @(posedge wr_clk or negedge nreset) begin
      if (!nreset) begin
         last_win <= 1'b1;
      end else if (wr_en) begin
         last_win <= win_idx;
      end
   end

   // one write port, so never two grants at once
   a_gnt_onehot : assert property (@(posedge wr_clk) disable iff (!nreset)
      $onehot0(gnt));

endmodule

//--- fifo/fifo_async.sv
`timescale 1ns/1ns

module fifo_async (
   input  logic               nreset,
   input  logic               wr_clk,
   input  logic               wr_en,
   input  emesh_pkg::packet_t din,
   input  logic               rd_clk,
   input  logic               rd_en,
   output emesh_pkg::packet_t dout,
   output logic               empty,
   output logic               full,
   output logic               prog_full
);
   import emesh_pkg::*;

   ptr_t wr_ptr;        // binary write pointer, wr_clk
   ptr_t rd_ptr;        // binary read pointer, rd_clk
   ptr_t wr_ptr_sync;   // write pointer seen from rd_clk
   ptr_t rd_ptr_sync;   // read pointer seen from wr_clk
   ptr_t wr_level;      // occupancy as the writer sees it

   //######################################################################
   // status flags
   //######################################################################

   // synced pointers lag, so flags only ever clear late
   assign wr_level  = wr_ptr - rd_ptr_sync;               // wraps cleanly with msb
   assign full      = (wr_level == ptr_t'(FIFO_DEPTH));
   assign prog_full = (wr_level >= ptr_t'(PROG_FULL));

   // equal including wrap bit means nothing left
   assign empty = (rd_ptr == wr_ptr_sync);

   //######################################################################
   // write side
   //######################################################################

   always_ff @(posedge wr_clk or negedge nreset) begin
      if (!nreset) begin
         wr_ptr <= '0;
      end else if (wr_en) begin
         wr_ptr <= wr_ptr + 1'b1;
      end
   end

   // write pointer across into rd_clk
   fifo_ptr_sync i_wr_sync (
      .nreset  (nreset),
      .src_clk (wr_clk),
      .dst_clk (rd_clk),
      .bin_in  (wr_ptr),
      .bin_out (wr_ptr_sync)
   );

   //######################################################################
   // read side
   //######################################################################

   always_ff @(posedge rd_clk or negedge nreset) begin
      if (!nreset) begin
         rd_ptr <= '0;
      end else if (rd_en) begin
         rd_ptr <= rd_ptr + 1'b1;
      end
   end

   // read pointer back into wr_clk
   fifo_ptr_sync i_rd_sync (
      .nreset  (nreset),
      .src_clk (rd_clk),
      .dst_clk (wr_clk),
      .bin_in  (rd_ptr),
      .bin_out (rd_ptr_sync)
   );

   //######################################################################
   // storage
   //######################################################################

   fifo_memory_dp i_mem (
      .wr_clk  (wr_clk),
      .wr_en   (wr_en),
      .wr_addr (wr_ptr[FIFO_AW-1:0]),   // drop wrap bit for address
      .wr_din  (din),
      .rd_clk  (rd_clk),
      .rd_en   (rd_en),
      .rd_addr (rd_ptr[FIFO_AW-1:0]),
      .rd_dout (dout)
   );

   // the writer must honour full, the reader must honour empty
   a_no_overflow : assert property (@(posedge wr_clk) disable iff (!nreset)
      wr_en |-> !full);

   a_no_underflow : assert property (@(posedge rd_clk) disable iff (!nreset)
      rd_en |-> !empty);

endmodule

//--- fifo/fifo_ptr_sync.sv
`timescale 1ns/1ns

module fifo_ptr_sync (
   input  logic            nreset,
   input  logic            src_clk,
   input  logic            dst_clk,
   input  emesh_pkg::ptr_t bin_in,
   output emesh_pkg::ptr_t bin_out
);
   import emesh_pkg::*;

   ptr_t gray_src;    // gray code, launched from src_clk
   ptr_t gray_meta;   // first dst flop, may go metastable
   ptr_t gray_dst;    // second dst flop, settled

   // bin to gray, registered so the crossing bus is glitch free
   always_ff @(posedge src_clk or negedge nreset) begin
      if (!nreset) begin
         gray_src <= '0;
      end else begin
         gray_src <= bin_in ^ (bin_in >> 1);
      end
   end

   // two flop synchronizer into dst_clk
   always_ff @(posedge dst_clk or negedge nreset) begin
      if (!nreset) begin
         gray_meta <= '0;
         gray_dst  <= '0;
      end else begin
         gray_meta <= gray_src;
         gray_dst  <= gray_meta;
      end
   end

   // gray to bin, each bit is xor of all gray bits at and above it
   always_comb begin
      for (int i = 0; i <= FIFO_AW; i++) begin
         bin_out[i] = ^(gray_dst >> i);
      end
   end

   // only one bit may move per launch, else the dst side can sample garbage
   a_gray_step : assert property (@(posedge src_clk) disable iff (!nreset)
      $countones(gray_src ^ $past(gray_src)) <= 1);

endmodule

//--- fifo/fifo_memory_dp.sv
`timescale 1ns/1ns

module fifo_memory_dp (
   input  logic                           wr_clk,
   input  logic                           wr_en,
   input  logic [emesh_pkg::FIFO_AW-1:0]  wr_addr,
   input  emesh_pkg::packet_t             wr_din,
   input  logic                           rd_clk,
   input  logic                           rd_en,
   input  logic [emesh_pkg::FIFO_AW-1:0]  rd_addr,
   output emesh_pkg::packet_t             rd_dout
);
   import emesh_pkg::*;

   packet_t mem [FIFO_DEPTH];   // storage array

   // write port, wr_clk domain
   always_ff @(posedge wr_clk) begin
      if (wr_en) begin
         mem[wr_addr] <= wr_din;
      end
   end

   // registered read port, rd_clk domain
   // holds last word until the next read
   always_ff @(posedge rd_clk) begin
      if (rd_en) begin
         rd_dout <= mem[rd_addr];
      end
   end

endmodule

//--- common/emesh_pkg.sv
package emesh_pkg;

   //######################################################################
   // fifo sizing
   //######################################################################

   localparam int FIFO_DEPTH = 16;   // entries
   localparam int FIFO_AW    = 4;    // log2 of depth
   localparam int PROG_FULL  = 8;    // near-full threshold, entries

   //######################################################################
   // payload
   //######################################################################

   localparam int DATA_W = 32;

   // one fifo entry, tagged with the source it came from
   typedef struct packed {
      logic              src;    // 0 or 1
      logic [DATA_W-1:0] data;
   } packet_t;

   // pointer with one extra wrap bit on top
   // msb differs when writer is a full lap ahead
   typedef logic [FIFO_AW:0] ptr_t;

endpackage
